/* verification/read_vectors.txt */
# name  start address (hex)  length in bytes (dec)  expected address phases (dec)
# Requests run back to back under random memory stalls
aligned_short    00000100   16  1
aligned_odd_len  00000204   13  1
unaligned_off1   00000301   20  1
unaligned_off2   00000402    7  1
unaligned_off3   00000503    9  1
single_beat      00000601    2  1
single_byte      00000703    1  1
long_aligned     00001000  200  4
long_unaligned   00002002  255  5
cross_4k         00000ff0   32  2
cross_4k_off1    00001ff9   40  2
cross_4k_long    00002f81  150  3
b2b_a            00004011   63  1
b2b_b            00004106   64  2
b2b_c            00004207    5  1
max_len          00005000  255  4

/* simple_axi_read.f */
+incdir+include
hdl/axi_bus_pkg.sv
hdl/xfer_pkg.sv
hdl/transfer_controller.sv
hdl/burst_align.sv
hdl/simple_axi_read.sv
verification/read_checker.sv
verification/tb_simple_axi_read.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_simple_axi_read -f simple_axi_read.f -o tb_sim \
   > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

/* verification/tb_simple_axi_read.sv */
`include "axi_read_defs.svh"

module tb_simple_axi_read;

   import axi_bus_pkg::*;
   import xfer_pkg::*;

   localparam int WAIT_LIMIT = 2000;   // Cycles allowed per request

   logic         clk = 1'b0;
   logic         rst;
   logic         m_rvalid;
   axi_addr_t    m_raddr;
   req_len_t     m_rlen;
   logic         m_rready;
   axi_data_t    m_rdata;
   logic         m_rlast;
   axi_addr_t    ar_addr;
   axi_len_t     ar_len;
   logic         ar_valid;
   logic         ar_ready = 1'b0;
   axi_data_t    r_data = '0;
   logic         r_valid = 1'b0;
   logic         r_last = 1'b0;
   logic         r_ready;

   logic         test_start;
   logic [127:0] test_name;
   logic [7:0]   test_bursts;
   int           tests_done;
   int           tests_failed;
   int           error_total;
   int           loaded = 0;
   logic         timed_out = 1'b0;
   logic         input_bad = 1'b0;

   // Slave memory state
   logic [31:0]  lfsr_q = 32'h610b050b;
   axi_addr_t    rd_addr = '0;
   int           rd_left = 0;
   logic         rd_active = 1'b0;
   int           ar_delay = 0;
   int           r_gap = 0;

   always #5 clk = ~clk;

   simple_axi_read dut0 (
      .clk_i        (clk),
      .rst_i        (rst),
      .m_rvalid_i   (m_rvalid),
      .m_raddr_i    (m_raddr),
      .m_rlen_i     (m_rlen),
      .m_rready_o   (m_rready),
      .m_rdata_o    (m_rdata),
      .m_rlast_o    (m_rlast),
      .axi_araddr_o (ar_addr),
      .axi_arlen_o  (ar_len),
      .axi_arvalid_o(ar_valid),
      .axi_arready_i(ar_ready),
      .axi_rdata_i  (r_data),
      .axi_rvalid_i (r_valid),
      .axi_rlast_i  (r_last),
      .axi_rready_o (r_ready)
   );

   read_checker read_check0 (
      .clk_i        (clk),
      .rst_i        (rst),
      .test_start_i (test_start),
      .test_name_i  (test_name),
      .test_addr_i  (m_raddr),     // Held for the whole request
      .test_len_i   (m_rlen),
      .test_bursts_i(test_bursts),
      .m_rready_i   (m_rready),
      .m_rdata_i    (m_rdata),
      .m_rlast_i    (m_rlast),
      .axi_araddr_i (ar_addr),
      .axi_arlen_i  (ar_len),
      .axi_arvalid_i(ar_valid),
      .axi_arready_i(ar_ready),
      .axi_rvalid_i (r_valid),
      .axi_rready_i (r_ready),
      .tests_o      (tests_done),
      .failed_o     (tests_failed),
      .errors_o     (error_total)
   );

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One step per bit taken
   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         value  = (value << 1) | int'(lfsr_q[0]);
      end
   endtask

   function automatic axi_data_t mem_word(axi_addr_t a);
      axi_data_t w;
      for (int k = 0; k < `BYTES_W; k++) begin
         w[8*k +: 8] = 8'((a + axi_addr_t'(k)) + ((a + axi_addr_t'(k)) >> 8));
      end
      return w;
   endfunction

   // AXI slave, one burst at a time with random stalls
   always @(posedge clk) begin
      logic      ar_fire;
      logic      r_fire;
      axi_addr_t ar_addr_s;
      axi_len_t  ar_len_s;
      ar_fire   = ar_valid && ar_ready;
      r_fire    = r_valid && r_ready;
      ar_addr_s = ar_addr;
      ar_len_s  = ar_len;
      #1;
      if (rst) begin
         ar_ready  = 1'b0;
         r_valid   = 1'b0;
         r_last    = 1'b0;
         rd_active = 1'b0;
      end else begin
         if (ar_fire) begin
            ar_ready  = 1'b0;
            rd_addr   = ar_addr_s;
            rd_left   = int'(ar_len_s) + 1;
            rd_active = 1'b1;
            draw_bits(2, ar_delay);
         end else if (ar_valid && !ar_ready && !rd_active) begin
            if (ar_delay == 0) begin
               ar_ready = 1'b1;
            end else begin
               ar_delay--;
            end
         end
         if (r_fire) begin
            r_valid = 1'b0;
            r_last  = 1'b0;
            rd_addr = rd_addr + 4;
            rd_left--;
            rd_active = (rd_left != 0);
            draw_bits(2, r_gap);
         end
         if (rd_active && !r_valid) begin
            if (r_gap == 0) begin
               r_valid = 1'b1;
               r_data  = mem_word(rd_addr);
               r_last  = (rd_left == 1);
            end else begin
               r_gap--;
            end
         end
      end
   end

   task automatic run_request(input logic [127:0] name, input axi_addr_t addr,
                              input req_len_t len, input logic [7:0] bursts);
      int cycles;
      m_rvalid    = 1'b1;
      m_raddr     = addr;
      m_rlen      = len;
      test_name   = name;
      test_bursts = bursts;
      test_start  = 1'b1;
      @(posedge clk);
      #1;
      test_start = 1'b0;
      cycles     = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!m_rlast && cycles < WAIT_LIMIT);
      if (!m_rlast) begin
         $display("timeout: no last word for %0s after %0d cycles", name, WAIT_LIMIT);
         timed_out = 1'b1;
      end
      @(posedge clk);
      #1;
      m_rvalid = 1'b0;   // Next request may follow at once
   endtask

   task automatic finish_run();
      $display("tests %0d failed %0d errors %0d", tests_done, tests_failed, error_total);
      if (!timed_out && !input_bad && tests_failed == 0 && error_total == 0 &&
          tests_done == loaded + 1) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   initial begin
      int           fd;
      int           n;
      string        line;
      logic [127:0] name;
      int unsigned  addr;
      int unsigned  len;
      int unsigned  bursts;
      rst         = 1'b1;
      m_rvalid    = 1'b0;
      m_raddr     = '0;
      m_rlen      = '0;
      test_start  = 1'b0;
      test_name   = '0;
      test_bursts = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (4) @(posedge clk);   // Idle outputs watched here
      #1;
      fd = $fopen("verification/read_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open verification/read_vectors.txt");
         input_bad = 1'b1;
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s %h %d %d", name, addr, len, bursts);
            if (n == 4) begin   // Skips comment and blank lines
               loaded++;
               run_request(name, axi_addr_t'(addr), req_len_t'(len), 8'(bursts));
            end
         end
         $fclose(fd);
         if (loaded == 0) begin
            $display("the vector file holds no requests");
            input_bad = 1'b1;
         end
      end
      repeat (5) @(posedge clk);
      finish_run();
   end

endmodule

/* verification/read_checker.sv */
`include "axi_read_defs.svh"

module read_checker (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   test_start_i,
   input  logic [127:0]           test_name_i,
   input  axi_bus_pkg::axi_addr_t test_addr_i,
   input  xfer_pkg::req_len_t     test_len_i,
   input  logic [7:0]             test_bursts_i,   // Expected address phases
   input  logic                   m_rready_i,
   input  axi_bus_pkg::axi_data_t m_rdata_i,
   input  logic                   m_rlast_i,
   input  axi_bus_pkg::axi_addr_t axi_araddr_i,
   input  axi_bus_pkg::axi_len_t  axi_arlen_i,
   input  logic                   axi_arvalid_i,
   input  logic                   axi_arready_i,
   input  logic                   axi_rvalid_i,
   input  logic                   axi_rready_i,
   output int                     tests_o,
   output int                     failed_o,
   output int                     errors_o
);

   import axi_bus_pkg::*;
   import xfer_pkg::*;

   logic [127:0] name_q;
   axi_addr_t    addr_q;
   req_len_t     len_q;
   axi_addr_t    next_ar_q;
   int           exp_bursts_q;
   int           exp_beats_q;
   int           words_q;
   int           bursts_q;
   int           ar_beats_q;
   int           r_beats_q;
   int           test_errs_q;
   int           tests_q;
   int           failed_q;
   int           errors_q;
   logic         active_q;
   logic         quiet_q;        // No request since reset
   logic [3:0]   quiet_seen_q;

   // Memory fill rule
   function automatic logic [7:0] mem_byte(axi_addr_t a);
      return 8'(a + (a >> 8));
   endfunction

   task automatic count_error();
      test_errs_q++;
      errors_q++;
   endtask

   task automatic close_test();
      int n_words;
      n_words = (int'(len_q) + `BYTES_W - 1) / `BYTES_W;
      if (words_q != n_words) begin
         $display("error %0s word count expected %0d actual %0d", name_q, n_words, words_q);
         count_error();
      end
      if (bursts_q != exp_bursts_q) begin
         $display("error %0s address phases expected %0d actual %0d", name_q, exp_bursts_q,
                  bursts_q);
         count_error();
      end
      if (ar_beats_q != exp_beats_q) begin
         $display("error %0s beats in ARLEN expected %0d actual %0d", name_q, exp_beats_q,
                  ar_beats_q);
         count_error();
      end
      if (r_beats_q != exp_beats_q) begin
         $display("error %0s data beats expected %0d actual %0d", name_q, exp_beats_q, r_beats_q);
         count_error();
      end
      if (test_errs_q == 0) begin
         $display("pass %0s", name_q);
      end else begin
         $display("fail %0s with %0d errors", name_q, test_errs_q);
         failed_q++;
      end
      tests_q++;
      active_q = 1'b0;
   endtask

   always @(posedge clk_i) begin
      axi_data_t exp_word;
      axi_data_t mask;
      int        n_words;
      if (rst_i) begin
         active_q     = 1'b0;
         quiet_q      = 1'b1;
         quiet_seen_q = '0;
         tests_q      = 0;
         failed_q     = 0;
         errors_q     = 0;
      end else begin
         if (quiet_q) begin
            quiet_seen_q = quiet_seen_q | {axi_arvalid_i, axi_rready_i, m_rready_i, m_rlast_i};
         end
         if (test_start_i) begin
            if (quiet_q) begin
               quiet_q = 1'b0;
               tests_q++;
               if (quiet_seen_q == '0) begin
                  $display("pass reset_idle");
               end else begin
                  $display("error reset_idle outputs expected 0000 actual %b", quiet_seen_q);
                  errors_q++;
                  failed_q++;
               end
            end
            name_q       = test_name_i;
            addr_q       = test_addr_i;
            len_q        = test_len_i;
            exp_bursts_q = int'(test_bursts_i);
            exp_beats_q  = (int'(test_addr_i[`OFFSET_W-1:0]) + int'(test_len_i) +
                            `BYTES_W - 1) / `BYTES_W;
            next_ar_q    = {test_addr_i[`AXI_ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
            words_q      = 0;
            bursts_q     = 0;
            ar_beats_q   = 0;
            r_beats_q    = 0;
            test_errs_q  = 0;
            active_q     = 1'b1;
         end

         if (axi_arvalid_i && axi_arready_i) begin
            if (axi_araddr_i !== next_ar_q) begin
               $display("error %0s burst address expected %h actual %h", name_q, next_ar_q,
                        axi_araddr_i);
               count_error();
            end
            if (int'(axi_arlen_i) + 1 > `MAX_BURST) begin
               $display("error %0s burst beats expected at most %0d actual %0d", name_q,
                        `MAX_BURST, int'(axi_arlen_i) + 1);
               count_error();
            end
            if (int'(axi_araddr_i[`BOUNDARY_W-1:0]) + (int'(axi_arlen_i) + 1) * `BYTES_W >
                (1 << `BOUNDARY_W)) begin
               $display("error %0s burst at %h crosses a 4 KB boundary", name_q, axi_araddr_i);
               count_error();
            end
            next_ar_q = axi_araddr_i + axi_addr_t'((int'(axi_arlen_i) + 1) * `BYTES_W);
            bursts_q++;
            ar_beats_q += int'(axi_arlen_i) + 1;
         end

         if (axi_rvalid_i && axi_rready_i) begin
            r_beats_q++;
         end

         if (m_rready_i) begin
            n_words  = (int'(len_q) + `BYTES_W - 1) / `BYTES_W;
            exp_word = '0;
            mask     = '0;
            for (int k = 0; k < `BYTES_W; k++) begin
               if (words_q * `BYTES_W + k < int'(len_q)) begin   // Lanes inside the request
                  exp_word[8*k +: 8] = mem_byte(addr_q + axi_addr_t'(words_q * `BYTES_W + k));
                  mask[8*k +: 8]     = 8'hff;
               end
            end
            if (!active_q) begin
               $display("error output word %h arrived with no request open", m_rdata_i);
               errors_q++;
            end else begin
               if ((m_rdata_i & mask) !== exp_word) begin
                  $display("error %0s word %0d expected %h actual %h", name_q, words_q, exp_word,
                           m_rdata_i & mask);
                  count_error();
               end
               if (m_rlast_i != (words_q == n_words - 1)) begin
                  $display("error %0s last flag on word %0d expected %0d actual %0d", name_q,
                           words_q, (words_q == n_words - 1), m_rlast_i);
                  count_error();
               end
               words_q++;
               if (m_rlast_i) begin
                  close_test();
               end
            end
         end else if (m_rlast_i) begin
            $display("error last flag raised without a valid output word");
            errors_q++;
         end
      end
   end

   assign tests_o  = tests_q;
   assign failed_o = failed_q;
   assign errors_o = errors_q;

endmodule

/* hdl/simple_axi_read.sv */
`include "axi_read_defs.svh"

module simple_axi_read (
   input  logic                   clk_i,
   input  logic                   rst_i,

   // Request port
   input  logic                   m_rvalid_i,
   input  axi_bus_pkg::axi_addr_t m_raddr_i,
   input  xfer_pkg::req_len_t     m_rlen_i,
   output logic                   m_rready_o,
   output axi_bus_pkg::axi_data_t m_rdata_o,
   output logic                   m_rlast_o,

   // AXI read address channel
   output axi_bus_pkg::axi_addr_t axi_araddr_o,
   output axi_bus_pkg::axi_len_t  axi_arlen_o,
   output logic                   axi_arvalid_o,
   input  logic                   axi_arready_i,

   // AXI read data channel
   input  axi_bus_pkg::axi_data_t axi_rdata_i,
   input  logic                   axi_rvalid_i,
   input  logic                   axi_rlast_i,
   output logic                   axi_rready_o
);

   import axi_bus_pkg::*;
   import xfer_pkg::*;

   read_state_t state_q;
   logic        arvalid_q;
   axi_len_t    arlen_q;

   axi_len_t    burst_len;
   logic        last_burst;
   logic        align_empty;
   logic        transfer_start;
   logic        burst_start;
   logic        beat;
   logic        burst_last;
   byte_off_t   start_off;
   beat_cnt_t   total_words;

   // Wait for the aligner so a held request is not taken twice
   assign transfer_start = (state_q == IDLE) && m_rvalid_i && align_empty;
   assign burst_start    = (state_q == ADDR) && arvalid_q && axi_arready_i;
   assign beat           = axi_rvalid_i && axi_rready_o;
   assign burst_last     = beat && axi_rlast_i;

   assign start_off   = m_raddr_i[`OFFSET_W-1:0];
   assign total_words = (beat_cnt_t'(m_rlen_i) + beat_cnt_t'(`BYTES_W - 1)) >> `OFFSET_W;

   transfer_controller read_controller (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .address_i       (m_raddr_i),
      .length_i        (m_rlen_i),
      .transfer_start_i(transfer_start),
      .burst_start_i   (burst_start),
      .burst_addr_o    (axi_araddr_o),
      .burst_len_o     (burst_len),
      .last_burst_o    (last_burst)
   );

   burst_align aligner (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .offset_i       (start_off),
      .start_i        (transfer_start),
      .data_in_i      (axi_rdata_i),
      .valid_in_i     (beat),
      .burst_last_i   (burst_last),
      .transfer_last_i(last_burst),
      .total_words_i  (total_words),
      .data_out_o     (m_rdata_o),
      .valid_out_o    (m_rready_o),
      .last_o         (m_rlast_o),
      .empty_o        (align_empty)
   );

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state_q   <= IDLE;
         arvalid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (transfer_start) begin
                  state_q <= SETUP;
               end
            end
            SETUP: begin
               arvalid_q <= 1'b1;
               state_q   <= ADDR;
            end
            ADDR: begin
               if (axi_arready_i) begin
                  arvalid_q <= 1'b0;
                  state_q   <= DATA;
               end
            end
            DATA: begin
               if (burst_last) begin
                  state_q <= last_burst ? IDLE : SETUP;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // ARLEN for the next burst
   always_ff @(posedge clk_i) begin
      if (state_q == SETUP) begin
         arlen_q <= burst_len;
      end
   end

   assign axi_arlen_o   = arlen_q;
   assign axi_arvalid_o = arvalid_q;
   assign axi_rready_o  = (state_q == DATA);

endmodule

/* hdl/burst_align.sv */
`include "axi_read_defs.svh"

module burst_align (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  axi_bus_pkg::byte_off_t offset_i,
   input  logic                   start_i,
   input  axi_bus_pkg::axi_data_t data_in_i,
   input  logic                   valid_in_i,
   input  logic                   burst_last_i,
   input  logic                   transfer_last_i,
   input  xfer_pkg::beat_cnt_t    total_words_i,
   output axi_bus_pkg::axi_data_t data_out_o,
   output logic                   valid_out_o,
   output logic                   last_o,
   output logic                   empty_o
);

   import axi_bus_pkg::*;
   import xfer_pkg::*;

   axi_data_t prev_q;
   axi_data_t out_q;
   logic      have_prev_q;
   logic      flush_q;     // Tail word owed after the final beat
   beat_cnt_t words_q;
   logic      valid_q;
   logic      last_q;
   logic      empty_q;

   logic      final_beat;
   logic      pair_fire;
   beat_cnt_t words_after_pair;
   logic      tail_need;
   logic      tail_now;
   logic      emit;
   axi_data_t emit_data;

   // Upper bytes of lo followed by lower bytes of hi
   function automatic axi_data_t join_lanes(axi_data_t hi, axi_data_t lo, byte_off_t off);
      logic [2*`AXI_DATA_W-1:0] both;
      both = {hi, lo} >> ((`AXI_DATA_W / `BYTES_W) * off);
      return both[`AXI_DATA_W-1:0];
   endfunction

   always_comb begin
      final_beat       = valid_in_i && burst_last_i && transfer_last_i;
      pair_fire        = valid_in_i && ((offset_i == '0) || have_prev_q);
      words_after_pair = words_q + beat_cnt_t'(pair_fire);
      // Last requested bytes sit in the final beat alone
      tail_need        = final_beat && (words_after_pair < total_words_i);
      tail_now         = tail_need && !pair_fire;
      emit             = pair_fire || tail_now || flush_q;
   end

   always_comb begin
      if (flush_q) begin
         emit_data = join_lanes('0, prev_q, offset_i);
      end else if (tail_now) begin
         emit_data = join_lanes('0, data_in_i, offset_i);
      end else if (offset_i == '0) begin
         emit_data = data_in_i;
      end else begin
         emit_data = join_lanes(data_in_i, prev_q, offset_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_in_i) begin
         prev_q <= data_in_i;
      end
      if (emit) begin
         out_q <= emit_data;
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         have_prev_q <= 1'b0;
         flush_q     <= 1'b0;
         words_q     <= '0;
         valid_q     <= 1'b0;
         last_q      <= 1'b0;
         empty_q     <= 1'b1;
      end else begin
         valid_q <= emit;
         last_q  <= emit && ((words_q + beat_cnt_t'(1)) == total_words_i);
         if (start_i) begin
            have_prev_q <= 1'b0;
            flush_q     <= 1'b0;
            words_q     <= '0;
            empty_q     <= 1'b0;
         end else begin
            if (valid_in_i) begin
               have_prev_q <= 1'b1;
            end
            flush_q <= tail_need && pair_fire;
            if (emit) begin
               words_q <= words_q + beat_cnt_t'(1);
            end
            if (last_q) begin
               empty_q <= 1'b1;  // One cycle after the last word
            end
         end
      end
   end

   assign data_out_o  = out_q;
   assign valid_out_o = valid_q;
   assign last_o      = last_q;
   assign empty_o     = empty_q;

endmodule

/* hdl/transfer_controller.sv */
`include "axi_read_defs.svh"

module transfer_controller (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  axi_bus_pkg::axi_addr_t address_i,
   input  xfer_pkg::req_len_t     length_i,    // In bytes
   input  logic                   transfer_start_i,
   input  logic                   burst_start_i,
   output axi_bus_pkg::axi_addr_t burst_addr_o,
   output axi_bus_pkg::axi_len_t  burst_len_o,
   output logic                   last_burst_o
);

   import axi_bus_pkg::*;
   import xfer_pkg::*;

   localparam int PAGE_IDX_W = `BOUNDARY_W - `OFFSET_W;

   axi_addr_t addr_q;
   beat_cnt_t remaining_q;
   logic      last_q;

   byte_off_t             start_off;
   beat_cnt_t             total_beats;
   logic [PAGE_IDX_W:0]   to_boundary;
   beat_cnt_t             burst_beats;

   // Beats needed to cover the leading offset plus the request
   always_comb begin
      start_off   = address_i[`OFFSET_W-1:0];
      total_beats = (beat_cnt_t'(start_off) + beat_cnt_t'(length_i) +
                     beat_cnt_t'(`BYTES_W - 1)) >> `OFFSET_W;
   end

   // Words left in the current 4 KB page
   always_comb begin
      to_boundary = {1'b1, {PAGE_IDX_W{1'b0}}} -
                    {1'b0, addr_q[`BOUNDARY_W-1:`OFFSET_W]};
   end

   // Smallest of remaining, burst limit and page limit
   always_comb begin
      burst_beats = remaining_q;
      if (burst_beats > beat_cnt_t'(`MAX_BURST)) begin
         burst_beats = beat_cnt_t'(`MAX_BURST);
      end
      if (to_boundary < {2'b00, burst_beats}) begin
         burst_beats = beat_cnt_t'(to_boundary);
      end
   end

   always_ff @(posedge clk_i) begin
      if (transfer_start_i) begin
         addr_q <= {address_i[`AXI_ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
      end else if (burst_start_i) begin
         addr_q <= addr_q + axi_addr_t'({burst_beats, {`OFFSET_W{1'b0}}});
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         remaining_q <= '0;
         last_q      <= 1'b0;
      end else if (transfer_start_i) begin
         remaining_q <= total_beats;
         last_q      <= 1'b0;
      end else if (burst_start_i) begin
         remaining_q <= remaining_q - burst_beats;
         // Flag follows the burst now in flight
         last_q      <= (remaining_q == burst_beats);
      end
   end

   assign burst_addr_o = addr_q;
   assign burst_len_o  = axi_len_t'(burst_beats - beat_cnt_t'(1));
   assign last_burst_o = last_q;

endmodule

/* hdl/xfer_pkg.sv */
`include "axi_read_defs.svh"

package xfer_pkg;

   // Requested length in bytes
   typedef logic [`LEN_W-1:0] req_len_t;

   // One extra bit, offset plus length can pass 255 bytes
   typedef logic [`LEN_W:0] beat_cnt_t;

   typedef enum logic [1:0] {
      IDLE,
      SETUP,   // Burst length latched here
      ADDR,    // ARVALID held until accepted
      DATA
   } read_state_t;

endpackage

/* hdl/axi_bus_pkg.sv */
`include "axi_read_defs.svh"

package axi_bus_pkg;

   // Byte address on the AXI read address channel
   typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

   // One read data beat
   typedef logic [`AXI_DATA_W-1:0] axi_data_t;

   // ARLEN holds beats minus one
   typedef logic [`AXI_LEN_W-1:0] axi_len_t;

   // Byte lane inside a data word
   typedef logic [`OFFSET_W-1:0] byte_off_t;

endpackage

/* include/axi_read_defs.svh */
`ifndef AXI_READ_DEFS_SVH
`define AXI_READ_DEFS_SVH

// AXI side
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_LEN_W  8   // ARLEN field

// Request length in bytes
`define LEN_W 8

// Byte lanes per data word
`define BYTES_W  4
`define OFFSET_W 2     // log2 of BYTES_W

// Burst splitting limits
`define MAX_BURST  16  // INCR beats per burst
`define BOUNDARY_W 12  // 4 KB page

`endif
